// File: project.f
hw/axi_pkg.sv
hw/cache_pkg.sv
hw/fill_req_fifo.sv
hw/fill_ctrl.sv
hw/line_assembler.sv
hw/line_fill_top.sv
tb/mem_responder.sv
tb/line_fill_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module line_fill_tb -Mdir obj_dir -f project.f
	out=$$(./obj_dir/Vline_fill_tb 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: tb/line_fill_tb.sv
`timescale 1ns/1ps
`default_nettype none

module line_fill_tb;

    import axi_pkg::*;
    import cache_pkg::*;

    localparam int LINE_BEATS = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int LINE_W     = LINE_BEATS * DATA_W;
    localparam int NUM_REQ    = 200;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_NS = NUM_REQ * 60 * CLK_PERIOD;
    localparam logic [31:0] LINE_MASK = ~32'(LINE_BEATS * 8 - 1);

    logic              clock;
    logic              reset;
    logic              req_valid;
    logic              req_ready;
    fill_req_t         req;
    logic              resp_valid;
    logic              resp_ready;
    logic [LINE_W-1:0] line;
    logic              err;
    logic              ar_valid;
    logic              ar_ready;
    axi_ar_t           ar;
    logic              r_valid;
    logic              r_ready;
    axi_r_t            r;

    logic [31:0] ar_q[$];
    logic [31:0] exp_q[$];
    int          sent;
    int          received;
    int          queued;
    logic        full_seen;

    line_fill_top #(
        .LINE_BEATS (LINE_BEATS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .line_o       (line),
        .err_o        (err),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .ar_o         (ar),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .r_i          (r)
    );

    mem_responder u_mem (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_i       (ar),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_o        (r)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // beat k of line A holds {~(A+8k), A+8k} with beat 0 lowest
    function automatic logic [LINE_W-1:0] expected_line(input logic [31:0] base);
        logic [LINE_W-1:0] result;
        logic [31:0]       addr;
        result = '0;
        for (int k = 0; k < LINE_BEATS; k++) begin
            addr = base + 32'(8 * k);
            result[k*DATA_W +: DATA_W] = {~addr, addr};
        end
        return result;
    endfunction

    task automatic check(input logic [LINE_W-1:0] actual, input logic [LINE_W-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail: time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the requests were not all answered in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    // reference model follows the handshakes on each rising edge
    always @(posedge clock) begin
        logic [31:0] exp_addr;
        if (!reset) begin
            check(req_ready, queued < FIFO_DEPTH, "req_ready_o");
            if (queued == FIFO_DEPTH) begin
                full_seen = 1'b1;
            end
            if (req_valid && req_ready) begin
                ar_q.push_back(req.addr & LINE_MASK);
                exp_q.push_back(req.addr & LINE_MASK);
                queued++;
            end
            if (ar_valid && ar_ready) begin
                check(ar_q.size() != 0, 1'b1, "address phase without a request");
                exp_addr = ar_q.pop_front();
                check(ar.addr, exp_addr, "ar_o.addr");
                check(ar.id, 0, "ar_o.id");
                check(ar.len, LINE_BEATS - 1, "ar_o.len");
                check(ar.size, 3, "ar_o.size");
                check(ar.burst, INCR, "ar_o.burst");
                queued--;
            end
            if (resp_valid && resp_ready) begin
                check(exp_q.size() != 0, 1'b1, "response without a request");
                exp_addr = exp_q.pop_front();
                check(line, expected_line(exp_addr), "line_o");
                check(err, exp_addr >= 32'h8000_0000, "err_o");
                received++;
            end
        end
    end

    initial begin
        logic accepted;
        int   gap;
        void'($urandom(22170));
        clock      = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        sent       = 0;
        received   = 0;
        queued     = 0;
        full_seen  = 1'b0;
        gap        = 0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        @(posedge clock);
        #2;
        check(req_ready, 1'b1, "req_ready_o after reset");
        check(ar_valid, 1'b0, "ar_valid_o after reset");
        check(r_ready, 1'b0, "r_ready_o after reset");
        check(resp_valid, 1'b0, "resp_valid_o after reset");
        check(err, 1'b0, "err_o after reset");
        while (received < NUM_REQ) begin
            @(posedge clock);
            accepted = req_valid && req_ready;
            #2;
            if (accepted) begin
                req_valid = 1'b0;
                // mostly back to back so the queue fills up
                gap = ($urandom_range(3) == 0) ? $urandom_range(8) : 0;
            end
            if (!req_valid && sent < NUM_REQ) begin
                if (gap == 0) begin
                    req_valid = 1'b1;
                    req.addr  = $urandom();
                    sent++;
                end else begin
                    gap--;
                end
            end
            resp_ready = ($urandom_range(3) != 0);
        end
        if (full_seen) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("The request queue never filled up, so a full queue was not tested");
            $display("Simulation finished: FAIL");
            $fatal(1, "queue never full");
        end
    end

endmodule

`default_nettype wire

// File: tb/mem_responder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_responder (
    input  wire                   clock,
    input  wire                   reset,

    input  wire                   ar_valid_i,
    output logic                  ar_ready_o,
    input  wire axi_pkg::axi_ar_t ar_i,

    output logic                  r_valid_o,
    input  wire                   r_ready_i,
    output axi_pkg::axi_r_t       r_o
);

    import axi_pkg::*;

    logic              busy;
    logic              in_reset;
    logic              taken;
    logic [ADDR_W-1:0] base;
    logic [7:0]        len;
    logic [7:0]        idx;

    // every beat carries its own byte address, upper half inverted
    function automatic axi_r_t make_beat(input logic [ADDR_W-1:0] addr, input logic last);
        axi_r_t beat;
        beat.data = {~addr, addr};
        beat.resp = (addr >= 32'h8000_0000) ? SLVERR : OKAY;
        beat.last = last;
        beat.id   = '0;
        return beat;
    endfunction

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        busy       = 1'b0;
        base       = '0;
        len        = '0;
        idx        = '0;
        forever begin
            @(posedge clock);
            in_reset = reset;
            taken    = r_valid_o && r_ready_i;
            if (in_reset) begin
                busy = 1'b0;
            end else if (ar_valid_i && ar_ready_o) begin
                busy = 1'b1;
                base = ar_i.addr;
                len  = ar_i.len;
                idx  = '0;
            end else if (taken) begin
                if (idx == len) begin
                    busy = 1'b0;
                end else begin
                    idx = idx + 1'b1;
                end
            end
            #2;
            // one burst at a time
            ar_ready_o = !in_reset && !busy && ($urandom_range(3) != 0);
            if (!busy) begin
                r_valid_o = 1'b0;
            end else if (!r_valid_o || taken) begin
                r_valid_o = ($urandom_range(2) != 0);
                r_o       = make_beat(base + (ADDR_W'(idx) << 3), idx == len);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/line_fill_top.sv
`timescale 1ns/1ps
`default_nettype none

module line_fill_top #(
    parameter int LINE_BEATS = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                  clock,
    input  wire                  reset,

    // cache request
    input  wire                  req_valid_i,
    output logic                 req_ready_o,
    input  wire cache_pkg::fill_req_t req_i,

    // cache response
    output logic                 resp_valid_o,
    input  wire                  resp_ready_i,
    output logic [LINE_BEATS*axi_pkg::DATA_W-1:0] line_o,
    output logic                 err_o,

    // AXI read address
    output logic                 ar_valid_o,
    input  wire                  ar_ready_i,
    output axi_pkg::axi_ar_t     ar_o,

    // AXI read data
    input  wire                  r_valid_i,
    output logic                 r_ready_o,
    input  wire axi_pkg::axi_r_t r_i
);

    import axi_pkg::*;
    import cache_pkg::*;

    logic      head_valid;
    fill_req_t head;
    logic      pop;
    logic      beat_en;
    axi_r_t    beat;
    logic      clear;

    fill_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock        (clock),
        .reset        (reset),
        .push_valid_i (req_valid_i),
        .push_ready_o (req_ready_o),
        .push_i       (req_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head)
    );

    fill_ctrl #(
        .LINE_BEATS (LINE_BEATS)
    ) u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .ar_o         (ar_o),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .r_i          (r_i),
        .beat_en_o    (beat_en),
        .beat_o       (beat),
        .clear_o      (clear),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i)
    );

    line_assembler #(
        .LINE_BEATS (LINE_BEATS)
    ) u_asm (
        .clock     (clock),
        .reset     (reset),
        .clear_i   (clear),
        .beat_en_i (beat_en),
        .beat_i    (beat),
        .line_o    (line_o),
        .err_o     (err_o)
    );

endmodule

`default_nettype wire

// File: hw/line_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module line_assembler #(
    parameter int LINE_BEATS = 4
) (
    input  wire                  clock,
    input  wire                  reset,

    input  wire                  clear_i,
    input  wire                  beat_en_i,
    input  wire axi_pkg::axi_r_t beat_i,

    output logic [LINE_BEATS*axi_pkg::DATA_W-1:0] line_o,
    output logic                                  err_o
);

    import axi_pkg::*;

    localparam int CNT_W = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;

    logic [CNT_W-1:0] wr_idx;
    logic             beat_err;

    assign beat_err = (beat_i.resp != OKAY);

    // beat k lands in slot k, beat 0 lowest
    always_ff @(posedge clock) begin
        if (beat_en_i) begin
            line_o[wr_idx * DATA_W +: DATA_W] <= beat_i.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_idx <= '0;
            err_o  <= 1'b0;
        end else if (clear_i) begin
            wr_idx <= '0;
            err_o  <= 1'b0;
        end else if (beat_en_i) begin
            wr_idx <= wr_idx + 1'b1;
            // sticky over the whole line
            err_o  <= err_o | beat_err;
        end
    end

endmodule

`default_nettype wire

// File: hw/fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fill_ctrl #(
    parameter int LINE_BEATS = 4
) (
    input  wire                  clock,
    input  wire                  reset,

    // head of the request queue
    input  wire                  head_valid_i,
    input  wire cache_pkg::fill_req_t head_i,
    output logic                 pop_o,

    // AXI read address
    output logic                 ar_valid_o,
    input  wire                  ar_ready_i,
    output axi_pkg::axi_ar_t     ar_o,

    // AXI read data
    input  wire                  r_valid_i,
    output logic                 r_ready_o,
    input  wire axi_pkg::axi_r_t r_i,

    // to the line assembler
    output logic                 beat_en_o,
    output axi_pkg::axi_r_t      beat_o,
    output logic                 clear_o,

    // line handshake towards the cache
    output logic                 resp_valid_o,
    input  wire                  resp_ready_i
);

    import axi_pkg::*;
    import cache_pkg::*;

    localparam int CNT_W      = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;
    localparam int LINE_BYTES = LINE_BEATS * BEAT_BYTES;

    // clears the offset bits inside a line
    localparam logic [ADDR_W-1:0] LINE_MASK = ~(ADDR_W'(LINE_BYTES) - 1'b1);

    fill_state_e      state;
    logic [CNT_W-1:0] beat_cnt;
    logic             last_beat;

    assign last_beat = (beat_cnt == CNT_W'(LINE_BEATS - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (head_valid_i) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (ar_ready_i) begin
                        state    <= DATA;
                        beat_cnt <= '0;
                    end
                end
                DATA: begin
                    if (beat_en_o) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    // line held here until the cache takes it
                    if (resp_ready_i) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // burst built straight from the queue head, stable until popped
    always_comb begin
        ar_o       = '0;
        ar_o.addr  = head_i.addr & LINE_MASK;
        ar_o.id    = '0;
        ar_o.len   = 8'(LINE_BEATS - 1);
        ar_o.size  = AXI_SIZE_BEAT;
        ar_o.burst = INCR;
    end

    assign ar_valid_o   = (state == ADDR);
    assign pop_o        = ar_valid_o && ar_ready_i;
    assign clear_o      = pop_o;
    assign r_ready_o    = (state == DATA);
    assign beat_en_o    = r_valid_i && r_ready_o;
    assign beat_o       = r_i;
    assign resp_valid_o = (state == DONE);

    // address phase must not change while the slave stalls it
    ar_stable_a: assert property (
        @(posedge clock) disable iff (reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
    );

    // slave marks exactly the final beat of the line as last
    last_on_final_beat_a: assert property (
        @(posedge clock) disable iff (reset)
        beat_en_o |-> (r_i.last == last_beat)
    );

endmodule

`default_nettype wire

// File: hw/fill_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fill_req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                  clock,
    input  wire                  reset,

    input  wire                  push_valid_i,
    output logic                 push_ready_o,
    input  wire cache_pkg::fill_req_t push_i,

    input  wire                  pop_i,
    output logic                 head_valid_o,
    output cache_pkg::fill_req_t head_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cache_pkg::fill_req_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign push_ready_o = (count != CNT_W'(FIFO_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];

    assign do_push = push_valid_i && push_ready_o;
    assign do_pop  = pop_i && head_valid_o;

    // request slots, written at the write pointer
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // controller only pops after it has seen a head
    pop_not_empty_a: assert property (
        @(posedge clock) disable iff (reset)
        pop_i |-> head_valid_o
    );

endmodule

`default_nettype wire

// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    import axi_pkg::*;

    localparam int unsigned LINE_ADDR_W = ADDR_W;

    // bytes carried by one beat of the line
    localparam int unsigned BEAT_BYTES = DATA_W / 8;

    typedef struct packed {
        logic [LINE_ADDR_W-1:0] addr;
    } fill_req_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        DONE = 2'd3
    } fill_state_e;

endpackage

`default_nettype wire

// File: hw/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned ID_W   = 4;

    // arsize encoding for a full-width beat
    localparam logic [2:0] AXI_SIZE_BEAT = 3'($clog2(DATA_W / 8));

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // read address channel payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [7:0]        len;
        logic [2:0]        size;
        axi_burst_e        burst;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
        logic [ID_W-1:0]   id;
    } axi_r_t;

endpackage

`default_nettype wire
